// ==== Makefile ====
TOP := tb_soc_periph_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f soc_periph_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== dv/tb_soc_periph_top.sv ====
// testbench for the peripheral subsystem, random requests checked against a register model
`timescale 1ns/1ps

module tb_soc_periph_top;

  import soc_periph_pkg::*;

  // about 400 requests at up to 10 cycles each, with margin
  localparam int CYCLE_LIMIT = 5000;
  // decode, slave access, response merge
  localparam int LATENCY     = 3;

  logic        sys_clk;
  logic        rst_n;
  logic        req_stb;
  logic        req_we;
  addr_t       req_addr;
  data_t       req_wdata;
  logic        rsp_stb;
  data_t       rsp_rdata;
  logic        rsp_err;
  gpio_t       gpio_in;
  gpio_t       gpio_out;
  gpio_t       gpio_dir;
  logic [1:0]  ext_irq;
  logic        mtip;
  logic        meip;

  // outstanding requests, oldest first
  data_t       exp_data_q[$];
  logic        exp_err_q[$];
  int          issue_q[$];

  int          cyc = 0;
  logic [63:0] edge_cnt = '0;
  int          errors;
  int          passes;
  int          rsp_bad = 0;
  int          rsp_ok = 0;
  int          test_err0;

  // register model
  gpio_t       m_out;
  gpio_t       m_dir;
  gpio_t       m_ie;
  gpio_t       m_ip;
  gpio_t       m_pins;
  logic [63:0] m_cmp;
  irq_t        m_pend;
  irq_t        m_en;
  irq_t        m_svc;

  soc_periph_top soc_periph_top_i (
    .i_sys_clk   (sys_clk),
    .i_rst_n     (rst_n),
    .i_req_stb   (req_stb),
    .i_req_we    (req_we),
    .i_req_addr  (req_addr),
    .i_req_wdata (req_wdata),
    .o_rsp_stb   (rsp_stb),
    .o_rsp_rdata (rsp_rdata),
    .o_rsp_err   (rsp_err),
    .i_gpio      (gpio_in),
    .o_gpio      (gpio_out),
    .o_gpio_dir  (gpio_dir),
    .i_ext_irq   (ext_irq),
    .o_mtip      (mtip),
    .o_meip      (meip)
  );

  initial
  begin
    sys_clk = 1'b0;
  end

  // 4 ns period
  always #2 sys_clk = ~sys_clk;

  // edge_cnt tracks the timer, which ticks on every edge out of reset
  always @(posedge sys_clk)
  begin
    cyc = cyc + 1;
    if (rst_n)
      edge_cnt = edge_cnt + 64'd1;
    if (cyc >= CYCLE_LIMIT)
    begin
      $display("run stopped at cycle %0d, requests still waiting for a response", cyc);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic bit values_match(input string sig, input data_t exp, input data_t got);
    if (got !== exp)
    begin
      $display("ERR %s exp %h got %h", sig, exp, got);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////////////

  // outputs move on the rising edge, so sample them on the falling one
  always @(negedge sys_clk)
  begin
    if (rst_n && rsp_stb)
    begin
      if (exp_data_q.size() == 0)
      begin
        $display("response at cycle %0d with no request outstanding", cyc);
        rsp_bad = rsp_bad + 1;
      end
      else
      begin
        if (cyc - issue_q[0] != LATENCY)
        begin
          $display("response came %0d cycles after its request instead of %0d",
                   cyc - issue_q[0], LATENCY);
          rsp_bad = rsp_bad + 1;
        end
        if (values_match("o_rsp_rdata", exp_data_q[0], rsp_rdata))
          rsp_ok = rsp_ok + 1;
        else
          rsp_bad = rsp_bad + 1;
        if (values_match("o_rsp_err", 32'(exp_err_q[0]), 32'(rsp_err)))
          rsp_ok = rsp_ok + 1;
        else
          rsp_bad = rsp_bad + 1;
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(issue_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus helpers, all entered on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string sig, input data_t exp, input data_t got);
    if (values_match(sig, exp, got))
      passes = passes + 1;
    else
      errors = errors + 1;
  endtask

  // unused address bits get random values
  function automatic addr_t make_addr(input logic [3:0] page, input reg_ofs_t ofs);
    logic [3:0] mid;
    logic [1:0] low;
    mid = 4'($urandom);
    low = 2'($urandom);
    return {page, mid, ofs, low};
  endfunction

  // one strobe cycle, the next request may follow at once
  task automatic issue(input logic we, input addr_t addr, input data_t wdata,
                       input data_t exp, input logic err);
    req_stb   = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    exp_data_q.push_back(exp);
    exp_err_q.push_back(err);
    issue_q.push_back(cyc);
    @(negedge sys_clk);
    req_stb = 1'b0;
  endtask

  task automatic drain;
    while (exp_data_q.size() != 0)
      @(negedge sys_clk);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge sys_clk);
  endtask

  // writes always answer with zero data
  task automatic write_reg(input logic [3:0] page, input reg_ofs_t ofs, input data_t wdata);
    issue(1'b1, make_addr(page, ofs), wdata, '0, 1'b0);
    drain();
  endtask

  task automatic read_reg(input logic [3:0] page, input reg_ofs_t ofs, input data_t exp);
    issue(1'b0, make_addr(page, ofs), '0, exp, 1'b0);
    drain();
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors + rsp_bad - test_err0);
    test_err0 = errors + rsp_bad;
  endtask

  function automatic reg_ofs_t pick_gpio_reg();
    case ($urandom_range(2))
      0:       return GPIO_OUT;
      1:       return GPIO_DIR;
      default: return GPIO_IE;
    endcase
  endfunction

  function automatic gpio_t gpio_model(input reg_ofs_t ofs);
    if (ofs == GPIO_OUT)
      return m_out;
    if (ofs == GPIO_DIR)
      return m_dir;
    return m_ie;
  endfunction

  task automatic set_gpio_model(input reg_ofs_t ofs, input gpio_t val);
    if (ofs == GPIO_OUT)
      m_out = val;
    else if (ofs == GPIO_DIR)
      m_dir = val;
    else
      m_ie = val;
  endtask

  // level sources pend unless in service, source 0 is grounded
  task automatic update_pend;
    m_pend = m_pend | ({ext_irq, |m_ip, 1'b0} & ~m_svc);
  endtask

  task automatic check_meip;
    check_word("o_meip", 32'(|(m_pend & m_en)), 32'(meip));
  endtask

  function automatic int lowest_ready(input irq_t ready);
    for (int i = 0; i < IRQ_N; i++)
      if (ready[i])
        return i;
    return -1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset;
    check_word("o_rsp_stb", '0, 32'(rsp_stb));
    check_word("o_rsp_err", '0, 32'(rsp_err));
    check_word("o_gpio", '0, 32'(gpio_out));
    check_word("o_gpio_dir", '0, 32'(gpio_dir));
    check_word("o_mtip", '0, 32'(mtip));
    check_word("o_meip", '0, 32'(meip));
  endtask

  task automatic test_gpio_regs;
    reg_ofs_t ofs;
    data_t    val;
    for (int i = 0; i < 40; i++)
    begin
      ofs = pick_gpio_reg();
      val = $urandom;
      write_reg(PAGE_GPIO, ofs, val);
      set_gpio_model(ofs, val[GPIO_W-1:0]);
      // upper bits are not stored
      read_reg(PAGE_GPIO, ofs, 32'(gpio_model(ofs)));
      check_word("o_gpio", 32'(m_out), 32'(gpio_out));
      check_word("o_gpio_dir", 32'(m_dir), 32'(gpio_dir));
    end
  endtask

  task automatic test_gpio_inputs;
    gpio_t pat;
    gpio_t clr;
    m_ie = gpio_t'($urandom);
    write_reg(PAGE_GPIO, GPIO_IE, 32'(m_ie));
    // only the gpio source reaches meip here
    m_en = 4'b0010;
    write_reg(PAGE_PLIC, PLIC_EN, 32'(m_en));
    for (int i = 0; i < 20; i++)
    begin
      pat     = gpio_t'($urandom);
      gpio_in = pat;
      m_ip    = m_ip | (pat & ~m_pins & m_ie);
      m_pins  = pat;
      // two sync flops, edge detect, gateway pend, meip flop
      wait_cycles(6);
      update_pend();
      read_reg(PAGE_GPIO, GPIO_IN, 32'(pat));
      read_reg(PAGE_GPIO, GPIO_IP, 32'(m_ip));
      check_meip();
      if ($urandom_range(1) == 1)
      begin
        clr = gpio_t'($urandom);
        write_reg(PAGE_GPIO, GPIO_IP, 32'(clr));
        m_ip = m_ip & ~clr;
        read_reg(PAGE_GPIO, GPIO_IP, 32'(m_ip));
      end
    end
    m_ie = '0;
    write_reg(PAGE_GPIO, GPIO_IE, '0);
    write_reg(PAGE_GPIO, GPIO_IP, 32'hfff);
    m_ip = '0;
    read_reg(PAGE_GPIO, GPIO_IP, '0);
  endtask

  task automatic test_timer;
    logic [63:0] t;
    logic [63:0] target;
    for (int i = 0; i < 4; i++)
    begin
      // the slave samples time one edge after the request edge
      t = edge_cnt + 64'd1;
      read_reg(PAGE_TIMER, TMR_TIME_LO, t[31:0]);
      t = edge_cnt + 64'd1;
      read_reg(PAGE_TIMER, TMR_TIME_HI, t[63:32]);
      // two writes take about 8 cycles before the deadline counts
      target = edge_cnt + 64'(8 + $urandom_range(60, 10));
      m_cmp  = target;
      write_reg(PAGE_TIMER, TMR_CMP_HI, target[63:32]);
      write_reg(PAGE_TIMER, TMR_CMP_LO, target[31:0]);
      // mtip is registered from the time value before each edge
      while (edge_cnt <= target + 64'd2)
      begin
        check_word("o_mtip", 32'(edge_cnt > target), 32'(mtip));
        @(negedge sys_clk);
      end
      read_reg(PAGE_TIMER, TMR_CMP_LO, m_cmp[31:0]);
    end
  endtask

  task automatic test_irq_gateway;
    irq_id_t id;
    int      k;
    for (int i = 0; i < 48; i++)
    begin
      case ($urandom_range(4))
        0:
        begin
          ext_irq = 2'($urandom);
          wait_cycles(3);
          update_pend();
        end
        1:
        begin
          m_en = irq_t'($urandom);
          write_reg(PAGE_PLIC, PLIC_EN, 32'(m_en));
        end
        2:
        begin
          k = lowest_ready(m_pend & m_en);
          if (k < 0)
            read_reg(PAGE_PLIC, PLIC_CLAIM, '0);
          else
          begin
            read_reg(PAGE_PLIC, PLIC_CLAIM, 32'(k));
            m_pend[k] = 1'b0;
            m_svc[k]  = 1'b1;
          end
        end
        3:
        begin
          id = irq_id_t'($urandom);
          write_reg(PAGE_PLIC, PLIC_CLAIM, 32'(id));
          m_svc[id] = 1'b0;
        end
        default:
          read_reg(PAGE_PLIC, PLIC_PEND, 32'(m_pend));
      endcase
      // completion re-pends one edge later, meip one more
      wait_cycles(2);
      update_pend();
      check_meip();
    end
  endtask

  task automatic test_burst;
    logic [3:0]  page;
    reg_ofs_t    ofs;
    data_t       val;
    logic [63:0] t;
    for (int i = 0; i < 60; i++)
    begin
      val = $urandom;
      case ($urandom_range(4))
        0:
        begin
          page = 4'($urandom);
          while (page == PAGE_GPIO || page == PAGE_TIMER || page == PAGE_PLIC)
            page = 4'($urandom);
          issue(1'($urandom), make_addr(page, reg_ofs_t'($urandom)), val, '0, 1'b1);
        end
        1:
        begin
          ofs = pick_gpio_reg();
          issue(1'b1, make_addr(PAGE_GPIO, ofs), val, '0, 1'b0);
          set_gpio_model(ofs, val[GPIO_W-1:0]);
        end
        2:
        begin
          ofs = pick_gpio_reg();
          issue(1'b0, make_addr(PAGE_GPIO, ofs), '0, 32'(gpio_model(ofs)), 1'b0);
        end
        3:
        begin
          t = edge_cnt + 64'd1;
          issue(1'b0, make_addr(PAGE_TIMER, TMR_TIME_LO), '0, t[31:0], 1'b0);
        end
        default:
          issue(1'b0, make_addr(PAGE_PLIC, PLIC_EN), '0, 32'(m_en), 1'b0);
      endcase
    end
    drain();
    check_word("o_gpio", 32'(m_out), 32'(gpio_out));
    check_word("o_gpio_dir", 32'(m_dir), 32'(gpio_dir));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'heb1b));
    rst_n     = 1'b0;
    req_stb   = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    gpio_in   = '0;
    ext_irq   = '0;
    m_out     = '0;
    m_dir     = '0;
    m_ie      = '0;
    m_ip      = '0;
    m_pins    = '0;
    m_cmp     = '1;
    m_pend    = '0;
    m_en      = '0;
    m_svc     = '0;
    errors    = 0;
    passes    = 0;
    test_err0 = 0;
    repeat (3) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;
    test_reset();
    finish_test("reset values");
    test_gpio_regs();
    finish_test("gpio registers");
    test_gpio_inputs();
    finish_test("gpio inputs and interrupts");
    test_timer();
    finish_test("timer and compare");
    test_irq_gateway();
    finish_test("interrupt gateway");
    test_burst();
    finish_test("back-to-back burst");
    $display("checks passed %0d, errors %0d", passes + rsp_ok, errors + rsp_bad);
    if (errors + rsp_bad == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== hdl/bus_decode.sv ====
// bus_decode: request stage, turns the address page into a one-hot slave strobe or an error
`timescale 1ns/1ps

module bus_decode (
  input  logic                     i_sys_clk,
  input  logic                     i_rst_n,
  input  logic                     i_req_stb,
  input  logic                     i_req_we,
  input  soc_periph_pkg::addr_t    i_req_addr,
  input  soc_periph_pkg::data_t    i_req_wdata,
  output soc_periph_pkg::slv_sel_t o_slv_stb,
  output logic                     o_slv_we,
  output soc_periph_pkg::reg_ofs_t o_slv_ofs,
  output soc_periph_pkg::data_t    o_slv_wdata,
  output logic                     o_err_stb
);

  import soc_periph_pkg::*;

  logic [3:0] page;
  slv_sel_t   sel;
  logic       hit;

  // top nibble picks the slave
  assign page = i_req_addr[15:12];

  always_comb
  begin
    sel = '0;
    hit = 1'b1;
    case (page)
      PAGE_GPIO:  sel[SLV_GPIO]  = 1'b1;
      PAGE_TIMER: sel[SLV_TIMER] = 1'b1;
      PAGE_PLIC:  sel[SLV_PLIC]  = 1'b1;
      // unmapped page, answered by resp_merge
      default:    hit = 1'b0;
    endcase
  end

  // strobes, one of them per accepted request
  always_ff @(posedge i_sys_clk)
  begin
    if (!i_rst_n)
    begin
      o_slv_stb <= '0;
      o_err_stb <= 1'b0;
    end
    else
    begin
      o_slv_stb <= i_req_stb ? sel : '0;
      o_err_stb <= i_req_stb & ~hit;
    end
  end

  // payload follows every cycle, qualified by the strobes
  always_ff @(posedge i_sys_clk)
  begin
    o_slv_we    <= i_req_we;
    o_slv_ofs   <= i_req_addr[7:2];
    o_slv_wdata <= i_req_wdata;
  end

  // exactly one path per request downstream
  a_stb_exclusive: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    $onehot0(o_slv_stb) && !(o_err_stb && (|o_slv_stb)));

endmodule

// ==== hdl/gpio_ctrl.sv ====
// gpio_ctrl: gpio output, direction and input registers with rising-edge interrupts
`timescale 1ns/1ps

module gpio_ctrl (
  input  logic                     i_sys_clk,
  input  logic                     i_rst_n,
  input  logic                     i_stb,
  input  logic                     i_we,
  input  soc_periph_pkg::reg_ofs_t i_ofs,
  input  soc_periph_pkg::data_t    i_wdata,
  input  soc_periph_pkg::gpio_t    i_gpio,
  output logic                     o_rsp_stb,
  output soc_periph_pkg::data_t    o_rsp_rdata,
  output soc_periph_pkg::gpio_t    o_gpio,
  output soc_periph_pkg::gpio_t    o_gpio_dir,
  output logic                     o_irq
);

  import soc_periph_pkg::*;

  gpio_t sync_q1;
  gpio_t sync_q2;
  gpio_t prev_q;
  gpio_t ie_q;
  gpio_t ip_q;
  gpio_t rise;
  gpio_t ip_clr;
  logic  wr;
  data_t rd_val;

  assign wr = i_stb & i_we;

  // enabled low-to-high transitions on the synchronised pins
  assign rise   = sync_q2 & ~prev_q & ie_q;
  // write one to clear
  assign ip_clr = (wr && i_ofs == GPIO_IP) ? i_wdata[GPIO_W-1:0] : '0;

  always_comb
  begin
    case (i_ofs)
      GPIO_IN:  rd_val = data_t'(sync_q2);
      GPIO_OUT: rd_val = data_t'(o_gpio);
      GPIO_DIR: rd_val = data_t'(o_gpio_dir);
      GPIO_IE:  rd_val = data_t'(ie_q);
      GPIO_IP:  rd_val = data_t'(ip_q);
      default:  rd_val = '0;
    endcase
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (!i_rst_n)
    begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      prev_q     <= '0;
      o_gpio     <= '0;
      o_gpio_dir <= '0;
      ie_q       <= '0;
      ip_q       <= '0;
      o_rsp_stb  <= 1'b0;
    end
    else
    begin
      // two-flop synchroniser, then one more for edge detect
      sync_q1 <= i_gpio;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (wr && i_ofs == GPIO_OUT)
        o_gpio <= i_wdata[GPIO_W-1:0];
      if (wr && i_ofs == GPIO_DIR)
        o_gpio_dir <= i_wdata[GPIO_W-1:0];
      if (wr && i_ofs == GPIO_IE)
        ie_q <= i_wdata[GPIO_W-1:0];
      // a new edge wins over a clear in the same cycle
      ip_q      <= (ip_q & ~ip_clr) | rise;
      o_rsp_stb <= i_stb;
    end
  end

  // writes and idle cycles return zero
  always_ff @(posedge i_sys_clk)
  begin
    o_rsp_rdata <= (i_stb && !i_we) ? rd_val : '0;
  end

  // one line to the gateway for all pins
  assign o_irq = |ip_q;

endmodule

// ==== hdl/irq_gateway.sv ====
// irq_gateway: level interrupt gateway with pending, enable, claim and complete
`timescale 1ns/1ps

module irq_gateway (
  input  logic                     i_sys_clk,
  input  logic                     i_rst_n,
  input  logic                     i_stb,
  input  logic                     i_we,
  input  soc_periph_pkg::reg_ofs_t i_ofs,
  input  soc_periph_pkg::data_t    i_wdata,
  input  soc_periph_pkg::irq_t     i_irq,
  output logic                     o_rsp_stb,
  output soc_periph_pkg::data_t    o_rsp_rdata,
  output logic                     o_meip
);

  import soc_periph_pkg::*;

  irq_t    pend_q;
  irq_t    en_q;
  irq_t    svc_q;
  irq_t    claim_mask;
  irq_t    done_mask;
  irq_id_t claim_id;
  logic    claim_hit;
  logic    wr;
  logic    rd;
  data_t   rd_val;

  assign wr = i_stb & i_we;
  assign rd = i_stb & ~i_we;

  // lowest pending and enabled source, scanned from the top down
  always_comb
  begin
    claim_id  = '0;
    claim_hit = 1'b0;
    for (int i = IRQ_N - 1; i >= 0; i--)
    begin
      if (pend_q[i] && en_q[i])
      begin
        claim_id  = irq_id_t'(i);
        claim_hit = 1'b1;
      end
    end
  end

  // claim moves the source from pending to in service
  assign claim_mask = (rd && i_ofs == PLIC_CLAIM && claim_hit) ? irq_t'(1) << claim_id : '0;
  // completion takes the source id from the write data
  assign done_mask  = (wr && i_ofs == PLIC_CLAIM) ? irq_t'(1) << irq_id_t'(i_wdata) : '0;

  always_comb
  begin
    case (i_ofs)
      PLIC_PEND:  rd_val = data_t'(pend_q);
      PLIC_EN:    rd_val = data_t'(en_q);
      PLIC_CLAIM: rd_val = data_t'(claim_id);
      default:    rd_val = '0;
    endcase
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (!i_rst_n)
    begin
      pend_q    <= '0;
      en_q      <= '0;
      svc_q     <= '0;
      o_meip    <= 1'b0;
      o_rsp_stb <= 1'b0;
    end
    else
    begin
      // a source in service is gated until it is completed
      pend_q <= (pend_q | (i_irq & ~svc_q)) & ~claim_mask;
      svc_q  <= (svc_q | claim_mask) & ~done_mask;
      if (wr && i_ofs == PLIC_EN)
        en_q <= i_wdata[IRQ_N-1:0];
      o_meip    <= |(pend_q & en_q);
      o_rsp_stb <= i_stb;
    end
  end

  always_ff @(posedge i_sys_clk)
  begin
    o_rsp_rdata <= rd ? rd_val : '0;
  end

  // source 0 is tied low at the top level and must never pend
  a_src0_idle: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    !$rose(pend_q[0]));

endmodule

// ==== hdl/mtimer.sv ====
// mtimer: 64-bit machine timer with compare register and timer interrupt
`timescale 1ns/1ps

module mtimer (
  input  logic                     i_sys_clk,
  input  logic                     i_rst_n,
  input  logic                     i_stb,
  input  logic                     i_we,
  input  soc_periph_pkg::reg_ofs_t i_ofs,
  input  soc_periph_pkg::data_t    i_wdata,
  output logic                     o_rsp_stb,
  output soc_periph_pkg::data_t    o_rsp_rdata,
  output logic                     o_mtip
);

  import soc_periph_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] cmp_q;
  logic        wr;
  data_t       rd_val;

  assign wr = i_stb & i_we;

  // halves of time and compare, time sampled in the access cycle
  always_comb
  begin
    case (i_ofs)
      TMR_TIME_LO: rd_val = mtime_q[31:0];
      TMR_TIME_HI: rd_val = mtime_q[63:32];
      TMR_CMP_LO:  rd_val = cmp_q[31:0];
      TMR_CMP_HI:  rd_val = cmp_q[63:32];
      default:     rd_val = '0;
    endcase
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (!i_rst_n)
    begin
      mtime_q   <= '0;
      // all ones keeps mtip low until software sets a deadline
      cmp_q     <= '1;
      o_mtip    <= 1'b0;
      o_rsp_stb <= 1'b0;
    end
    else
    begin
      // free running, one tick per edge
      mtime_q <= mtime_q + 64'd1;
      if (wr && i_ofs == TMR_CMP_LO)
        cmp_q[31:0] <= i_wdata;
      if (wr && i_ofs == TMR_CMP_HI)
        cmp_q[63:32] <= i_wdata;
      // level, stays high until compare is moved ahead
      o_mtip    <= (mtime_q >= cmp_q);
      o_rsp_stb <= i_stb;
    end
  end

  always_ff @(posedge i_sys_clk)
  begin
    o_rsp_rdata <= (i_stb && !i_we) ? rd_val : '0;
  end

endmodule

// ==== hdl/resp_merge.sv ====
// resp_merge: response stage, merges slave read data and the decode error into one response
`timescale 1ns/1ps

module resp_merge (
  input  logic                     i_sys_clk,
  input  logic                     i_rst_n,
  input  soc_periph_pkg::slv_sel_t i_rsp_stb,
  input  soc_periph_pkg::data_t    i_rsp_rdata_gpio,
  input  soc_periph_pkg::data_t    i_rsp_rdata_tmr,
  input  soc_periph_pkg::data_t    i_rsp_rdata_plic,
  input  logic                     i_err_stb,
  output logic                     o_rsp_stb,
  output soc_periph_pkg::data_t    o_rsp_rdata,
  output logic                     o_rsp_err
);

  import soc_periph_pkg::*;

  logic  err_q;
  data_t rdata_sel;

  // strobe-qualified OR of the slave read data
  assign rdata_sel = ({$bits(data_t){i_rsp_stb[SLV_GPIO]}}  & i_rsp_rdata_gpio) |
                     ({$bits(data_t){i_rsp_stb[SLV_TIMER]}} & i_rsp_rdata_tmr)  |
                     ({$bits(data_t){i_rsp_stb[SLV_PLIC]}}  & i_rsp_rdata_plic);

  always_ff @(posedge i_sys_clk)
  begin
    if (!i_rst_n)
    begin
      err_q     <= 1'b0;
      o_rsp_stb <= 1'b0;
      o_rsp_err <= 1'b0;
    end
    else
    begin
      // error waits one stage, in step with the slave access
      err_q     <= i_err_stb;
      o_rsp_stb <= (|i_rsp_stb) | err_q;
      o_rsp_err <= err_q;
    end
  end

  // zero for errors, no slave strobes then
  always_ff @(posedge i_sys_clk)
  begin
    o_rsp_rdata <= rdata_sel;
  end

  // only the addressed slave answers
  a_one_slave: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
    $onehot0(i_rsp_stb));

endmodule

// ==== hdl/soc_periph_pkg.sv ====
// soc_periph_pkg: address map, slot numbers, widths and bus types of the peripheral subsystem
package soc_periph_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // gpio pin count, matches the 12-bit controller of the full soc
  localparam int GPIO_W = 12;
  // gateway sources, 0 is reserved and tied low
  localparam int IRQ_N  = 4;

  // bus byte address
  typedef logic [15:0]       addr_t;
  // bus data word
  typedef logic [31:0]       data_t;
  // word index inside a 4 KB page, address bits 7..2
  typedef logic [5:0]        reg_ofs_t;
  // one bit per slave slot
  typedef logic [2:0]        slv_sel_t;
  typedef logic [GPIO_W-1:0] gpio_t;
  typedef logic [IRQ_N-1:0]  irq_t;
  typedef logic [1:0]        irq_id_t;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // slave slots, index into slv_sel_t
  localparam int SLV_GPIO  = 0;
  localparam int SLV_TIMER = 1;
  localparam int SLV_PLIC  = 2;

  // page values, compared against address bits 15..12
  localparam logic [3:0] PAGE_GPIO  = 4'h1;
  localparam logic [3:0] PAGE_TIMER = 4'h2;
  localparam logic [3:0] PAGE_PLIC  = 4'hC;

  // gpio registers
  localparam reg_ofs_t GPIO_IN  = 6'd0;
  localparam reg_ofs_t GPIO_OUT = 6'd1;
  localparam reg_ofs_t GPIO_DIR = 6'd2;
  localparam reg_ofs_t GPIO_IE  = 6'd3;
  localparam reg_ofs_t GPIO_IP  = 6'd4;

  // timer registers, time is read-only
  localparam reg_ofs_t TMR_TIME_LO = 6'd0;
  localparam reg_ofs_t TMR_TIME_HI = 6'd1;
  localparam reg_ofs_t TMR_CMP_LO  = 6'd2;
  localparam reg_ofs_t TMR_CMP_HI  = 6'd3;

  // gateway registers
  localparam reg_ofs_t PLIC_PEND  = 6'd0;
  localparam reg_ofs_t PLIC_EN    = 6'd1;
  // read claims, write completes
  localparam reg_ofs_t PLIC_CLAIM = 6'd2;

endpackage

// ==== hdl/soc_periph_top.sv ====
// soc_periph_top: peripheral subsystem with decode, gpio, timer, interrupt gateway and response
`timescale 1ns/1ps

module soc_periph_top (
  input  logic                  i_sys_clk,
  input  logic                  i_rst_n,
  // request
  input  logic                  i_req_stb,
  input  logic                  i_req_we,
  input  soc_periph_pkg::addr_t i_req_addr,
  input  soc_periph_pkg::data_t i_req_wdata,
  // response
  output logic                  o_rsp_stb,
  output soc_periph_pkg::data_t o_rsp_rdata,
  output logic                  o_rsp_err,
  // pins
  input  soc_periph_pkg::gpio_t i_gpio,
  output soc_periph_pkg::gpio_t o_gpio,
  output soc_periph_pkg::gpio_t o_gpio_dir,
  // external sources 2 and 3
  input  logic [1:0]            i_ext_irq,
  output logic                  o_mtip,
  output logic                  o_meip
);

  import soc_periph_pkg::*;

  slv_sel_t slv_stb;
  logic     slv_we;
  reg_ofs_t slv_ofs;
  data_t    slv_wdata;
  logic     err_stb;
  slv_sel_t rsp_stb;
  data_t    rdata_gpio;
  data_t    rdata_tmr;
  data_t    rdata_plic;
  logic     gpio_irq;
  irq_t     irq_src;

  // source 0 stays grounded
  assign irq_src = {i_ext_irq, gpio_irq, 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, address decode
  ////////////////////////////////////////////////////////////////////////////
  bus_decode decode0 (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_req_stb   (i_req_stb),
    .i_req_we    (i_req_we),
    .i_req_addr  (i_req_addr),
    .i_req_wdata (i_req_wdata),
    .o_slv_stb   (slv_stb),
    .o_slv_we    (slv_we),
    .o_slv_ofs   (slv_ofs),
    .o_slv_wdata (slv_wdata),
    .o_err_stb   (err_stb)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, slaves
  ////////////////////////////////////////////////////////////////////////////
  // page 0x1
  gpio_ctrl gpio0 (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_stb       (slv_stb[SLV_GPIO]),
    .i_we        (slv_we),
    .i_ofs       (slv_ofs),
    .i_wdata     (slv_wdata),
    .i_gpio      (i_gpio),
    .o_rsp_stb   (rsp_stb[SLV_GPIO]),
    .o_rsp_rdata (rdata_gpio),
    .o_gpio      (o_gpio),
    .o_gpio_dir  (o_gpio_dir),
    .o_irq       (gpio_irq)
  );

  // page 0x2, clint-like timer
  mtimer clint0 (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_stb       (slv_stb[SLV_TIMER]),
    .i_we        (slv_we),
    .i_ofs       (slv_ofs),
    .i_wdata     (slv_wdata),
    .o_rsp_stb   (rsp_stb[SLV_TIMER]),
    .o_rsp_rdata (rdata_tmr),
    .o_mtip      (o_mtip)
  );

  // page 0xC, plic-like gateway
  irq_gateway plic0 (
    .i_sys_clk   (i_sys_clk),
    .i_rst_n     (i_rst_n),
    .i_stb       (slv_stb[SLV_PLIC]),
    .i_we        (slv_we),
    .i_ofs       (slv_ofs),
    .i_wdata     (slv_wdata),
    .i_irq       (irq_src),
    .o_rsp_stb   (rsp_stb[SLV_PLIC]),
    .o_rsp_rdata (rdata_plic),
    .o_meip      (o_meip)
  );

  // stage 3, response
  resp_merge merge0 (
    .i_sys_clk        (i_sys_clk),
    .i_rst_n          (i_rst_n),
    .i_rsp_stb        (rsp_stb),
    .i_rsp_rdata_gpio (rdata_gpio),
    .i_rsp_rdata_tmr  (rdata_tmr),
    .i_rsp_rdata_plic (rdata_plic),
    .i_err_stb        (err_stb),
    .o_rsp_stb        (o_rsp_stb),
    .o_rsp_rdata      (o_rsp_rdata),
    .o_rsp_err        (o_rsp_err)
  );

endmodule

// ==== soc_periph_top.f ====
hdl/soc_periph_pkg.sv
hdl/bus_decode.sv
hdl/gpio_ctrl.sv
hdl/mtimer.sv
hdl/irq_gateway.sv
hdl/resp_merge.sv
hdl/soc_periph_top.sv
dv/tb_soc_periph_top.sv
